// ==== riscv_isa_pkg.sv ====
package riscv_isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int inst_w     = 32;
    localparam int opcode_w   = 7;
    localparam int funct3_w   = 3;
    localparam int funct7_w   = 7;

    // field positions inside the instruction word
    localparam int opcode_lsb = 0;
    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;
    localparam int funct7_lsb = 25;

    localparam logic [opcode_w-1:0] op_imm    = 7'b0010011;
    localparam logic [opcode_w-1:0] op_reg    = 7'b0110011;
    localparam logic [opcode_w-1:0] op_branch = 7'b1100011;
    localparam logic [opcode_w-1:0] op_jal    = 7'b1101111;
    localparam logic [opcode_w-1:0] op_jalr   = 7'b1100111;
    localparam logic [opcode_w-1:0] op_lui    = 7'b0110111;
    localparam logic [opcode_w-1:0] op_auipc  = 7'b0010111;
    localparam logic [opcode_w-1:0] op_fence  = 7'b0001111;

    localparam logic [funct3_w-1:0] f3_add_sub = 3'b000; // alu group
    localparam logic [funct3_w-1:0] f3_sll     = 3'b001;
    localparam logic [funct3_w-1:0] f3_slt     = 3'b010;
    localparam logic [funct3_w-1:0] f3_sltu    = 3'b011;
    localparam logic [funct3_w-1:0] f3_xor     = 3'b100;
    localparam logic [funct3_w-1:0] f3_srl_sra = 3'b101;
    localparam logic [funct3_w-1:0] f3_or      = 3'b110;
    localparam logic [funct3_w-1:0] f3_and     = 3'b111;

    localparam logic [funct3_w-1:0] f3_beq  = 3'b000; // branch group
    localparam logic [funct3_w-1:0] f3_bne  = 3'b001;
    localparam logic [funct3_w-1:0] f3_blt  = 3'b100;
    localparam logic [funct3_w-1:0] f3_bge  = 3'b101;
    localparam logic [funct3_w-1:0] f3_bltu = 3'b110;
    localparam logic [funct3_w-1:0] f3_bgeu = 3'b111;
    localparam logic [funct3_w-1:0] f3_jalr = 3'b000;

    localparam logic [funct3_w-1:0] f3_mul    = 3'b000; // rv32m div and rem use 1xx
    localparam logic [funct3_w-1:0] f3_mulh   = 3'b001;
    localparam logic [funct3_w-1:0] f3_mulhsu = 3'b010;
    localparam logic [funct3_w-1:0] f3_mulhu  = 3'b011;

    localparam logic [funct7_w-1:0] funct7_base   = 7'b0000000;
    localparam logic [funct7_w-1:0] funct7_alt    = 7'b0100000; // sub, sra, srai
    localparam logic [funct7_w-1:0] funct7_muldiv = 7'b0000001;

    localparam logic [xlen-1:0] pc_step = 32'd4;

endpackage

// ==== exec_pkg.sv ====
package exec_pkg;

    import riscv_isa_pkg::*;

    localparam int mul_op_w = xlen + 1; // one extra bit carries the operand sign

    typedef enum logic [4:0] {
        ex_add, ex_sub, ex_sll, ex_slt, ex_sltu,
        ex_xor, ex_srl, ex_sra, ex_or, ex_and,
        ex_lui, ex_auipc, ex_branch, ex_jal, ex_jalr,
        ex_mul, ex_mulh, ex_mulhsu, ex_mulhu,
        ex_nop, ex_illegal
    } exec_op_e;

    typedef struct packed {
        logic [inst_w-1:0] inst;
        logic [xlen-1:0]   pc;
        logic [xlen-1:0]   rs1_data;
        logic [xlen-1:0]   rs2_data;
    } issue_t;

    typedef struct packed {
        exec_op_e              op;
        logic [reg_addr_w-1:0] rd;
        logic [funct3_w-1:0]   funct3;
        logic                  src2_imm; // second alu operand is imm, not rs2
        logic [xlen-1:0]       imm;
    } decoded_t;

    typedef struct packed {
        exec_op_e              op;
        logic [reg_addr_w-1:0] rd;
        logic                  we;
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       pc_next;
        logic                  illegal;
        logic [mul_op_w-1:0]   mul_a;
        logic [mul_op_w-1:0]   mul_b;
    } stage_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       wdata;
        logic [xlen-1:0]       pc_next;
        logic                  illegal;
    } result_t;

endpackage

// ==== inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode (
    input  logic [riscv_isa_pkg::inst_w-1:0] inst_i,
    output exec_pkg::decoded_t               dec_o
);
    import riscv_isa_pkg::*;
    import exec_pkg::*;

    logic [opcode_w-1:0] opcode;
    logic [funct3_w-1:0] funct3;
    logic [funct7_w-1:0] funct7;
    logic [xlen-1:0]     imm_i;
    logic [xlen-1:0]     imm_b;
    logic [xlen-1:0]     imm_u;
    logic [xlen-1:0]     imm_j;
    exec_op_e            base_op;

    assign opcode = inst_i[opcode_lsb +: opcode_w];
    assign funct3 = inst_i[funct3_lsb +: funct3_w];
    assign funct7 = inst_i[funct7_lsb +: funct7_w];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'h000};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // funct3 map shared by register and immediate forms
    always_comb begin
        case (funct3)
            f3_add_sub: base_op = ex_add;
            f3_sll:     base_op = ex_sll;
            f3_slt:     base_op = ex_slt;
            f3_sltu:    base_op = ex_sltu;
            f3_xor:     base_op = ex_xor;
            f3_srl_sra: base_op = ex_srl;
            f3_or:      base_op = ex_or;
            default:    base_op = ex_and;
        endcase
    end

    always_comb begin
        dec_o          = '0;
        dec_o.rd       = inst_i[rd_lsb +: reg_addr_w];
        dec_o.funct3   = funct3;
        dec_o.op       = ex_illegal; // anything not matched below
        case (opcode)
            op_imm: begin
                dec_o.imm      = imm_i;
                dec_o.src2_imm = 1'b1;
                if (funct3 == f3_sll) begin
                    if (funct7 == funct7_base) dec_o.op = ex_sll;
                end else if (funct3 == f3_srl_sra) begin
                    if (funct7 == funct7_base) dec_o.op = ex_srl;
                    else if (funct7 == funct7_alt) dec_o.op = ex_sra;
                end else begin
                    dec_o.op = base_op;
                end
            end
            op_reg: begin
                case (funct7)
                    funct7_base: dec_o.op = base_op;
                    funct7_alt: begin
                        if (funct3 == f3_add_sub) dec_o.op = ex_sub;
                        else if (funct3 == f3_srl_sra) dec_o.op = ex_sra;
                    end
                    funct7_muldiv: begin
                        case (funct3)
                            f3_mul:    dec_o.op = ex_mul;
                            f3_mulh:   dec_o.op = ex_mulh;
                            f3_mulhsu: dec_o.op = ex_mulhsu;
                            f3_mulhu:  dec_o.op = ex_mulhu;
                            default:   dec_o.op = ex_illegal; // div and rem
                        endcase
                    end
                    default: dec_o.op = ex_illegal;
                endcase
            end
            op_branch: begin
                dec_o.imm = imm_b;
                if (funct3 inside {f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu}) begin
                    dec_o.op = ex_branch;
                end
            end
            op_jal: begin
                dec_o.imm = imm_j;
                dec_o.op  = ex_jal;
            end
            op_jalr: begin
                dec_o.imm = imm_i;
                if (funct3 == f3_jalr) dec_o.op = ex_jalr;
            end
            op_lui: begin
                dec_o.imm = imm_u;
                dec_o.op  = ex_lui;
            end
            op_auipc: begin
                dec_o.imm      = imm_u;
                dec_o.src2_imm = 1'b1; // pc + imm through the alu adder
                dec_o.op       = ex_auipc;
            end
            op_fence: dec_o.op = ex_nop;
            default:  dec_o.op = ex_illegal;
        endcase
    end

endmodule

// ==== int_alu.sv ====
`timescale 1ns/1ps

module int_alu (
    input  exec_pkg::issue_t               issue_i,
    input  exec_pkg::decoded_t             dec_i,
    input  logic [riscv_isa_pkg::xlen-1:0] pc_next_i,
    input  logic [riscv_isa_pkg::xlen-1:0] link_i,
    output exec_pkg::stage_t               stage_o
);
    import riscv_isa_pkg::*;
    import exec_pkg::*;

    logic [xlen-1:0] opa;
    logic [xlen-1:0] opb;
    logic            sub_en;
    logic [xlen-1:0] sum;
    logic            lt_s;
    logic            lt_u;
    logic [4:0]      shamt;
    logic [xlen-1:0] result;
    logic            is_mul;
    logic            rs1_signed;
    logic            rs2_signed;
    logic            no_write;

    assign opa    = (dec_i.op == ex_auipc) ? issue_i.pc : issue_i.rs1_data;
    assign opb    = dec_i.src2_imm ? dec_i.imm : issue_i.rs2_data;
    assign sub_en = (dec_i.op == ex_sub);
    assign sum    = opa + (sub_en ? ~opb : opb) + {{(xlen-1){1'b0}}, sub_en}; // add, sub, auipc

    assign lt_s  = $signed(issue_i.rs1_data) < $signed(opb);
    assign lt_u  = issue_i.rs1_data < opb;
    assign shamt = opb[4:0];

    always_comb begin
        case (dec_i.op)
            ex_add, ex_sub, ex_auipc: result = sum;
            ex_sll:           result = issue_i.rs1_data << shamt;
            ex_srl:           result = issue_i.rs1_data >> shamt;
            ex_sra:           result = $signed(issue_i.rs1_data) >>> shamt;
            ex_slt:           result = {{(xlen-1){1'b0}}, lt_s};
            ex_sltu:          result = {{(xlen-1){1'b0}}, lt_u};
            ex_xor:           result = issue_i.rs1_data ^ opb;
            ex_or:            result = issue_i.rs1_data | opb;
            ex_and:           result = issue_i.rs1_data & opb;
            ex_lui:           result = dec_i.imm;
            ex_jal, ex_jalr:  result = link_i;
            default:          result = '0; // mul is resolved after s1
        endcase
    end

    assign is_mul     = dec_i.op inside {ex_mul, ex_mulh, ex_mulhsu, ex_mulhu};
    assign rs1_signed = dec_i.op inside {ex_mul, ex_mulh, ex_mulhsu};
    assign rs2_signed = dec_i.op inside {ex_mul, ex_mulh};
    assign no_write   = dec_i.op inside {ex_branch, ex_nop, ex_illegal};

    always_comb begin
        stage_o            = '0;
        stage_o.op         = dec_i.op;
        stage_o.rd         = dec_i.rd;
        stage_o.we         = !no_write;
        stage_o.alu_result = result;
        stage_o.illegal    = (dec_i.op == ex_illegal);
        stage_o.pc_next    = stage_o.illegal ? '0 : pc_next_i;
        if (is_mul) begin // operands stay zero otherwise
            stage_o.mul_a = {rs1_signed & issue_i.rs1_data[xlen-1], issue_i.rs1_data};
            stage_o.mul_b = {rs2_signed & issue_i.rs2_data[xlen-1], issue_i.rs2_data};
        end
    end

endmodule

// ==== branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    input  exec_pkg::issue_t               issue_i,
    input  exec_pkg::decoded_t             dec_i,
    output logic [riscv_isa_pkg::xlen-1:0] pc_next_o,
    output logic [riscv_isa_pkg::xlen-1:0] link_o
);
    import riscv_isa_pkg::*;
    import exec_pkg::*;

    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic            taken;
    logic [xlen-1:0] base;
    logic [xlen-1:0] target;

    assign eq   = issue_i.rs1_data == issue_i.rs2_data;
    assign lt_s = $signed(issue_i.rs1_data) < $signed(issue_i.rs2_data);
    assign lt_u = issue_i.rs1_data < issue_i.rs2_data;

    always_comb begin
        case (dec_i.funct3)
            f3_beq:  taken = eq;
            f3_bne:  taken = !eq;
            f3_blt:  taken = lt_s;
            f3_bge:  taken = !lt_s;
            f3_bltu: taken = lt_u;
            f3_bgeu: taken = !lt_u;
            default: taken = 1'b0;
        endcase
    end

    assign base   = (dec_i.op == ex_jalr) ? issue_i.rs1_data : issue_i.pc;
    assign target = base + dec_i.imm; // bit 0 of the jalr target is not cleared
    assign link_o = issue_i.pc + pc_step;

    assign pc_next_o = ((dec_i.op == ex_branch && taken) || dec_i.op inside {ex_jal, ex_jalr})
                       ? target : link_o;

endmodule

// ==== mul_writeback.sv ====
`timescale 1ns/1ps

module mul_writeback (
    input  exec_pkg::stage_t  stage_i,
    output exec_pkg::result_t result_o
);
    import riscv_isa_pkg::*;
    import exec_pkg::*;

    logic signed [2*mul_op_w-1:0] product;

    // both operands already carry the right sign bit
    assign product = $signed(stage_i.mul_a) * $signed(stage_i.mul_b);

    always_comb begin
        result_o.we      = stage_i.we;
        result_o.rd      = stage_i.rd;
        result_o.pc_next = stage_i.pc_next;
        result_o.illegal = stage_i.illegal;
        case (stage_i.op)
            ex_mul:                        result_o.wdata = product[xlen-1:0];
            ex_mulh, ex_mulhsu, ex_mulhu:  result_o.wdata = product[2*xlen-1:xlen]; // high word
            default:                       result_o.wdata = stage_i.alu_result;
        endcase
    end

endmodule

// ==== pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    logic     valid_q;
    payload_t data_q;

    assign ready_o = !valid_q || ready_i; // empty, or current item leaves now

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

// ==== exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  exec_pkg::issue_t  in_data_i,
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output exec_pkg::result_t out_data_o
);
    import riscv_isa_pkg::*;
    import exec_pkg::*;

    decoded_t        dec;
    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] link;
    stage_t          s1_in;
    stage_t          s1_out;
    logic            s1_valid;
    logic            s2_ready;
    result_t         s2_in;

    inst_decode u_decode (
        .inst_i (in_data_i.inst),
        .dec_o  (dec)
    );

    branch_unit u_branch (
        .issue_i   (in_data_i),
        .dec_i     (dec),
        .pc_next_o (pc_next),
        .link_o    (link)
    );

    int_alu u_alu (
        .issue_i   (in_data_i),
        .dec_i     (dec),
        .pc_next_i (pc_next),
        .link_i    (link),
        .stage_o   (s1_in)
    );

    pipe_reg #(.payload_t(stage_t)) u_s1 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (in_valid_i),
        .ready_o (in_ready_o),
        .data_i  (s1_in),
        .valid_o (s1_valid),
        .ready_i (s2_ready),
        .data_o  (s1_out)
    );

    mul_writeback u_mul_wb (
        .stage_i  (s1_out),
        .result_o (s2_in)
    );

    pipe_reg #(.payload_t(result_t)) u_s2 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (s1_valid),
        .ready_o (s2_ready),
        .data_i  (s2_in),
        .valid_o (out_valid_o),
        .ready_i (out_ready_i),
        .data_o  (out_data_o)
    );

endmodule

// ==== exec_asserts.sv ====
`timescale 1ns/1ps

module exec_asserts (
    input logic              clk,
    input logic              rst_n_i,
    input logic              out_valid_i,
    input logic              out_ready_i,
    input exec_pkg::result_t out_data_i
);

    int fail_count = 0; // read by the testbench top

    a_idle_after_reset: assert property (@(posedge clk) $rose(rst_n_i) |-> !out_valid_i)
    else begin
        $error("out_valid_o high right after reset");
        fail_count++;
    end

    // a stalled result must not change
    a_data_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_i && !out_ready_i |=> $stable(out_data_i))
    else begin
        $error("out_data_o changed while stalled");
        fail_count++;
    end

    a_valid_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_i && !out_ready_i |=> out_valid_i)
    else begin
        $error("out_valid_o dropped without a transfer");
        fail_count++;
    end

endmodule

bind exec_stage exec_asserts u_asserts (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_i  (out_data_o)
);

// ==== exec_checker.sv ====
`timescale 1ns/1ps

module exec_checker (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              in_ready_i,
    input  logic              exp_push_i,
    input  exec_pkg::result_t exp_i,
    input  logic              out_valid_i,
    input  logic              out_ready_i,
    input  exec_pkg::result_t out_data_i,
    output int                pass_cnt_o,
    output int                fail_cnt_o,
    output int                done_cnt_o
);
    import exec_pkg::*;

    result_t exp_q[$];
    int      push_cyc_q[$];
    int      cycle      = 0;
    int      last_stall = 0; // last edge with out_ready_i low
    int      passed     = 0;
    int      failed     = 0;
    int      done       = 0;
    bit      idle_seen  = 0;

    assign pass_cnt_o = passed;
    assign fail_cnt_o = failed;
    assign done_cnt_o = done;

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] got, inout bit ok);
        if (exp !== got) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
            ok = 0;
        end
    endtask

    task automatic check_output();
        result_t exp;
        int      push_cyc;
        bit      ok;
        if (exp_q.size() == 0) begin
            $display("output transfer at %0t with no test pending", $time);
            failed++;
        end else begin
            exp      = exp_q.pop_front();
            push_cyc = push_cyc_q.pop_front();
            ok       = 1;
            compare_field("out_data_o.illegal", exp.illegal, out_data_i.illegal, ok);
            compare_field("out_data_o.we", exp.we, out_data_i.we, ok);
            compare_field("out_data_o.pc_next", exp.pc_next, out_data_i.pc_next, ok);
            if (exp.we) begin // rd and wdata only mean something on a write
                compare_field("out_data_o.rd", exp.rd, out_data_i.rd, ok);
                compare_field("out_data_o.wdata", exp.wdata, out_data_i.wdata, ok);
            end
            if (last_stall <= push_cyc) begin // no stall since the input transfer
                compare_field("latency", 32'd2, cycle - push_cyc, ok);
            end
            $display("test %0d %s", done, ok ? "passed" : "failed");
            if (ok) passed++;
            else    failed++;
            done++;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n_i) begin
            cycle++;
            if (!idle_seen) begin // first edge out of reset
                idle_seen = 1;
                if (out_valid_i || !in_ready_i) begin
                    $display("FAILED at %0t: out_valid_o/in_ready_o expected 0/1, got %b/%b",
                             $time, out_valid_i, in_ready_i);
                    failed++;
                end
            end
            if (!out_ready_i) last_stall = cycle;
            if (out_valid_i && out_ready_i) check_output();
            if (exp_push_i) begin
                exp_q.push_back(exp_i);
                push_cyc_q.push_back(cycle);
            end
        end
    end

endmodule

// ==== tb_exec_stage.sv ====
`timescale 1ns/1ps

module tb_exec_stage;
    import riscv_isa_pkg::*;
    import exec_pkg::*;

    logic    clk;
    logic    rst_n_i;
    logic    in_valid_i;
    logic    in_ready_o;
    issue_t  in_data_i;
    logic    out_valid_o;
    logic    out_ready_i;
    result_t out_data_o;
    result_t exp_data;
    logic    exp_push;
    int      pass_cnt;
    int      fail_cnt;
    int      done_cnt;
    int      sent_cnt = 0;
    issue_t  stim_q[$];
    result_t exp_q[$];

    exec_stage DUT (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_data_i   (in_data_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (out_data_o)
    );

    assign exp_push = in_valid_i && in_ready_o; // high for the transfer edge only

    exec_checker u_checker (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_ready_i  (in_ready_o),
        .exp_push_i  (exp_push),
        .exp_i       (exp_data),
        .out_valid_i (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_i  (out_data_o),
        .pass_cnt_o  (pass_cnt),
        .fail_cnt_o  (fail_cnt),
        .done_cnt_o  (done_cnt)
    );

    // encoders use rs1 = x1, rs2 = x2 and rd = x5
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd5, op_reg};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [6:0] op);
        return {imm, 5'd1, f3, 5'd5, op};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [6:0] op);
        return {imm, 5'd5, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd5, op_jal};
    endfunction

    task automatic add_entry(input logic [31:0] inst, input logic [31:0] rs1,
                             input logic [31:0] rs2, input logic we, input logic [31:0] wdata,
                             input logic [31:0] pc_next, input logic illegal);
        issue_t  iss;
        result_t res;
        iss.inst     = inst;
        iss.pc       = 32'h0000_1000; // every entry sits at the same pc
        iss.rs1_data = rs1;
        iss.rs2_data = rs2;
        res.we       = we;
        res.rd       = 5'd5;
        res.wdata    = wdata;
        res.pc_next  = pc_next;
        res.illegal  = illegal;
        stim_q.push_back(iss);
        exp_q.push_back(res);
    endtask

    task automatic alu_case(input logic [31:0] inst, input logic [31:0] rs1,
                            input logic [31:0] rs2, input logic [31:0] wdata);
        add_entry(inst, rs1, rs2, 1'b1, wdata, 32'h0000_1004, 1'b0);
    endtask

    task automatic no_write_case(input logic [31:0] inst, input logic [31:0] rs1,
                                 input logic [31:0] rs2, input logic [31:0] pc_next);
        add_entry(inst, rs1, rs2, 1'b0, 32'h0, pc_next, 1'b0);
    endtask

    task automatic jump_case(input logic [31:0] inst, input logic [31:0] rs1,
                             input logic [31:0] pc_next);
        add_entry(inst, rs1, 32'h0, 1'b1, 32'h0000_1004, pc_next, 1'b0);
    endtask

    task automatic illegal_case(input logic [31:0] inst);
        add_entry(inst, $urandom(), $urandom(), 1'b0, 32'h0, 32'h0, 1'b1);
    endtask

    task automatic build_table();
        alu_case(r_type(funct7_base, f3_add_sub), 32'd7, 32'd5, 32'd12);
        alu_case(r_type(funct7_alt, f3_add_sub), 32'd5, 32'd7, 32'hFFFF_FFFE);
        alu_case(r_type(funct7_base, f3_sll), 32'h1, 32'h24, 32'h10); // amount 4 from low bits
        alu_case(r_type(funct7_base, f3_srl_sra), 32'h8000_0000, 32'd4, 32'h0800_0000);
        alu_case(r_type(funct7_alt, f3_srl_sra), 32'h8000_0000, 32'd4, 32'hF800_0000);
        alu_case(r_type(funct7_base, f3_slt), 32'hFFFF_FFFF, 32'd1, 32'd1);
        alu_case(r_type(funct7_base, f3_sltu), 32'hFFFF_FFFF, 32'd1, 32'd0);
        alu_case(r_type(funct7_base, f3_xor), 32'hF0F0_F0F0, 32'h0FF0_0FF0, 32'hFF00_FF00);
        alu_case(r_type(funct7_base, f3_or), 32'hF0F0_0000, 32'h0000_0F0F, 32'hF0F0_0F0F);
        alu_case(r_type(funct7_base, f3_and), 32'hF0F0_F0F0, 32'h0FF0_0FF0, 32'h00F0_00F0);
        alu_case(i_type(12'hFFF, f3_add_sub, op_imm), 32'd10, 32'd0, 32'd9);
        alu_case(i_type(12'h408, f3_srl_sra, op_imm), 32'h8000_0000, 32'd0, 32'hFF80_0000);
        alu_case(i_type(12'h008, f3_srl_sra, op_imm), 32'h8000_0000, 32'd0, 32'h0080_0000);
        alu_case(i_type(12'hFFF, f3_slt, op_imm), 32'h7FFF_FFFF, 32'd0, 32'd0);
        alu_case(i_type(12'hFFF, f3_sltu, op_imm), 32'h7FFF_FFFF, 32'd0, 32'd1);
        alu_case(i_type(12'h0FF, f3_and, op_imm), 32'h1234_5678, 32'd0, 32'h78);
        alu_case(u_type(20'hABCDE, op_lui), 32'd0, 32'd0, 32'hABCD_E000);
        alu_case(u_type(20'h00001, op_auipc), 32'd0, 32'd0, 32'h0000_2000);
        no_write_case(b_type(13'd16, f3_beq), 32'd5, 32'd5, 32'h0000_1010);
        no_write_case(b_type(13'd16, f3_beq), 32'd5, 32'd6, 32'h0000_1004);
        no_write_case(b_type(-13'd8, f3_bne), 32'd5, 32'd6, 32'h0000_0FF8);
        no_write_case(b_type(13'd16, f3_bne), 32'd5, 32'd5, 32'h0000_1004);
        no_write_case(b_type(13'd16, f3_blt), 32'hFFFF_FFFF, 32'd1, 32'h0000_1010);
        no_write_case(b_type(13'd16, f3_blt), 32'd1, 32'hFFFF_FFFF, 32'h0000_1004);
        no_write_case(b_type(13'd16, f3_bge), 32'd1, 32'hFFFF_FFFF, 32'h0000_1010);
        no_write_case(b_type(13'd16, f3_bge), 32'hFFFF_FFFF, 32'd1, 32'h0000_1004);
        no_write_case(b_type(13'd16, f3_bltu), 32'd1, 32'hFFFF_FFFF, 32'h0000_1010);
        no_write_case(b_type(13'd16, f3_bltu), 32'hFFFF_FFFF, 32'd1, 32'h0000_1004);
        no_write_case(b_type(13'd16, f3_bgeu), 32'hFFFF_FFFF, 32'd1, 32'h0000_1010);
        no_write_case(b_type(13'd16, f3_bgeu), 32'd1, 32'hFFFF_FFFF, 32'h0000_1004);
        no_write_case({12'h0FF, 5'd0, 3'b000, 5'd0, op_fence}, 32'd0, 32'd0, 32'h0000_1004);
        jump_case(j_type(21'h100), 32'd0, 32'h0000_1100);
        jump_case(j_type(-21'd32), 32'd0, 32'h0000_0FE0);
        jump_case(i_type(12'h010, f3_jalr, op_jalr), 32'h0000_2000, 32'h0000_2010);
        jump_case(i_type(12'hFFC, f3_jalr, op_jalr), 32'h0000_3000, 32'h0000_2FFC);
        alu_case(r_type(funct7_muldiv, f3_mul), 32'hFFFF_FFFE, 32'd3, 32'hFFFF_FFFA);
        alu_case(r_type(funct7_muldiv, f3_mul), 32'h1234_5678, 32'h10, 32'h2345_6780);
        alu_case(r_type(funct7_muldiv, f3_mulh), 32'hFFFF_FFFE, 32'd3, 32'hFFFF_FFFF);
        alu_case(r_type(funct7_muldiv, f3_mulh), 32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
        alu_case(r_type(funct7_muldiv, f3_mulhsu), 32'hFFFF_FFFE, 32'd3, 32'hFFFF_FFFF);
        alu_case(r_type(funct7_muldiv, f3_mulhsu), 32'd3, 32'hFFFF_FFFE, 32'h0000_0002);
        alu_case(r_type(funct7_muldiv, f3_mulhsu), 32'h8000_0000, 32'h8000_0000, 32'hC000_0000);
        alu_case(r_type(funct7_muldiv, f3_mulhu), 32'hFFFF_FFFE, 32'd3, 32'h0000_0002);
        alu_case(r_type(funct7_muldiv, f3_mulhu), 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE);
        illegal_case(r_type(funct7_muldiv, 3'b100)); // div
        illegal_case(i_type(12'h004, 3'b010, 7'b0000011)); // lw
        illegal_case(i_type(12'h300, 3'b001, 7'b1110011)); // csrrw
        illegal_case(i_type(12'h000, 3'b000, 7'b1111111));
        illegal_case(r_type(7'h7F, f3_add_sub));
    endtask

    task automatic drive_all();
        for (int i = 0; i < stim_q.size(); i++) begin
            @(negedge clk);
            in_valid_i = 1'b1;
            in_data_i  = stim_q[i];
            exp_data   = exp_q[i];
            @(posedge clk);
            while (!in_ready_o) @(posedge clk); // held until accepted
            sent_cnt++;
        end
        @(negedge clk);
        in_valid_i = 1'b0;
    endtask

    // sink back-pressure in the later half
    task automatic apply_backpressure();
        forever begin
            @(negedge clk);
            if (sent_cnt >= stim_q.size() / 2) out_ready_i = ($urandom() & 32'd1) != 0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        void'($urandom(32'h330d2466));
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        in_data_i   = '0;
        exp_data    = '0;
        out_ready_i = 1'b1;
        build_table();
        fork
            apply_backpressure();
            begin
                repeat (stim_q.size() * 20 + 40) @(posedge clk);
                $display("timeout: only %0d of %0d results arrived", done_cnt, stim_q.size());
                $display("Something failed");
                $finish;
            end
        join_none
        repeat (16) @(negedge clk);
        rst_n_i = 1'b1;
        drive_all();
        wait (done_cnt == stim_q.size());
        repeat (4) @(negedge clk); // room for a duplicated result to show up
        $display("%0d tests passed, %0d failed, %0d assertion failures",
                 pass_cnt, fail_cnt, DUT.u_asserts.fail_count);
        if (fail_cnt == 0 && DUT.u_asserts.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
riscv_isa_pkg.sv
exec_pkg.sv
inst_decode.sv
int_alu.sv
branch_unit.sv
mul_writeback.sv
pipe_reg.sv
exec_stage.sv
exec_asserts.sv
exec_checker.sv
tb_exec_stage.sv
